// ==== uart_rx_pkg.sv ====
package uart_rx_pkg;

  // --------------------------------------------------
  // Bit timing
  // --------------------------------------------------
  localparam int OVERSAMPLE        = 16; // Ticks per bit
  localparam int PHASE_W           = 4;
  localparam int CENTER_PHASE      = 8;  // Sample point of each bit
  localparam int FILTER_INIT_PHASE = 4;  // Majority count cleared here

  // --------------------------------------------------
  // Receive data
  // --------------------------------------------------
  typedef logic [7:0] char_t; // Upper bits zero for short words

  // One FIFO word, flags above the character
  typedef struct packed {
    logic  par_err;
    logic  frame_err;
    logic  brk;
    char_t char;
  } rx_entry_t;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  typedef enum logic [1:0] {WLEN_5, WLEN_6, WLEN_7, WLEN_8} word_len_e;

  typedef enum logic [1:0] {PAR_ODD, PAR_EVEN, PAR_FORCE1, PAR_FORCE0} parity_e;

  typedef struct packed {
    logic [1:0] rsvd_7_6;
    parity_e    par_type;
    logic       par_en;
    logic       rsvd_2;
    word_len_e  word_len;
  } lcr_t;

  typedef struct packed {
    logic [1:0] trig_level;  // 1, 4, 8 or 14 chars
    logic [3:0] rsvd_5_2;
    logic       rx_fifo_rst; // Self clearing
    logic       rsvd_0;
  } fcr_t;

  typedef struct packed {
    logic [2:0] rsvd_7_5;
    logic       brk;
    logic       frame_err;
    logic       par_err;
    logic       overrun;
    logic       data_ready;
  } lsr_t;

  // Word addresses
  localparam logic [1:0] ADDR_RHR = 2'd0;
  localparam logic [1:0] ADDR_LCR = 2'd1;
  localparam logic [1:0] ADDR_FCR = 2'd2;
  localparam logic [1:0] ADDR_LSR = 2'd3;

  // --------------------------------------------------
  // Wishbone classic
  // --------------------------------------------------
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

endpackage

// ==== uart_rx_bit_timing.sv ====
module uart_rx_bit_timing #(
  parameter int CLKS_PER_TICK = 8
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            start_seen_i, // Falling edge while idle
  input  logic                            idle_i,
  output logic                            tick_o,
  output logic [uart_rx_pkg::PHASE_W-1:0] phase_o,
  output logic                            center_o
);

  localparam int PW          = uart_rx_pkg::PHASE_W;
  localparam int DIV_W       = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam int START_PHASE = 2; // Makes up for sync and detect delay

  logic [DIV_W-1:0] div_q;
  logic [PW-1:0]    phase_q;
  logic             at_center;
  logic             at_center_q;

  // --------------------------------------------------
  // Oversample tick divider
  // --------------------------------------------------
  assign tick_o = (div_q == DIV_W'(CLKS_PER_TICK - 1)); // One clock wide

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q <= '0;
    end else if (tick_o) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // Phase within the bit
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= '0;
    end else if (start_seen_i) begin
      phase_q <= PW'(START_PHASE); // Realign on start edge
    end else if (idle_i) begin
      phase_q <= '0;
    end else if (tick_o) begin
      if (phase_q == PW'(uart_rx_pkg::OVERSAMPLE - 1)) begin
        phase_q <= '0;
      end else begin
        phase_q <= phase_q + 1'b1;
      end
    end
  end

  assign phase_o = phase_q;

  // Center strobe on entry into the center phase
  assign at_center = (phase_q == PW'(uart_rx_pkg::CENTER_PHASE));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      at_center_q <= 1'b0;
    end else begin
      at_center_q <= at_center;
    end
  end

  assign center_o = at_center & ~at_center_q;

  // Bit centers only occur inside a frame
  a_center_in_frame : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    center_o |-> !idle_i)
    else $error("bit center strobe while the receiver is idle");

endmodule

// ==== uart_rx_line_filter.sv ====
module uart_rx_line_filter (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            rxd_i,      // Raw pin
  input  logic                            tick_i,
  input  logic [uart_rx_pkg::PHASE_W-1:0] phase_i,
  output logic                            rxd_sync_o,
  output logic                            bit_o       // Majority of three
);

  localparam int PW = uart_rx_pkg::PHASE_W;

  logic [1:0] sync_q;
  logic [1:0] high_cnt_q;
  logic       bit_q;
  logic       init_phase;
  logic       count_phase;
  logic       vote_phase;

  // --------------------------------------------------
  // Two flop synchronizer
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '1; // Idle line is high
    end else begin
      sync_q <= {sync_q[0], rxd_i};
    end
  end

  assign rxd_sync_o = sync_q[1];

  // --------------------------------------------------
  // Majority filter
  // --------------------------------------------------
  assign init_phase  = (phase_i == PW'(uart_rx_pkg::FILTER_INIT_PHASE));
  assign vote_phase  = (phase_i == PW'(uart_rx_pkg::FILTER_INIT_PHASE + 3)); // Phase 7
  assign count_phase = (phase_i > PW'(uart_rx_pkg::FILTER_INIT_PHASE)) &&
                       (phase_i < PW'(uart_rx_pkg::FILTER_INIT_PHASE + 3));  // Phases 5, 6

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      high_cnt_q <= '0;
      bit_q      <= 1'b1;
    end else if (init_phase) begin
      high_cnt_q <= '0;
    end else if (tick_i) begin
      if (vote_phase) begin
        // Third sample folded into the vote
        bit_q <= high_cnt_q[1] | (high_cnt_q[0] & rxd_sync_o);
      end else if (count_phase && rxd_sync_o) begin
        high_cnt_q <= high_cnt_q + 1'b1;
      end
    end
  end

  assign bit_o = bit_q; // Settled before center strobe

endmodule

// ==== uart_rx_deframer.sv ====
module uart_rx_deframer (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   rxd_sync_i,
  input  logic                   bit_i,      // Filtered sample
  input  logic                   center_i,
  input  uart_rx_pkg::lcr_t      lcr_i,
  output logic                   start_seen_o,
  output logic                   idle_o,
  output logic                   push_o,
  output uart_rx_pkg::rx_entry_t entry_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP, ST_RESYNC
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  uart_rx_pkg::char_t     shift_q;   // LSB first
  uart_rx_pkg::rx_entry_t entry_q;
  logic [2:0]             bit_cnt_q;
  logic [2:0]             last_idx;  // Index of last data bit
  logic                   par_err_q;
  logic                   par_err_d;
  logic                   ones_q;    // Any high bit so far
  logic                   push_q;
  logic                   stop_done;

  assign last_idx  = 3'(lcr_i.word_len) + 3'd4;
  assign stop_done = (state_q == ST_STOP) & center_i;

  // --------------------------------------------------
  // Parity check
  // --------------------------------------------------
  always_comb begin
    case (lcr_i.par_type)
      uart_rx_pkg::PAR_ODD:    par_err_d = (bit_i == ^shift_q);
      uart_rx_pkg::PAR_EVEN:   par_err_d = (bit_i != ^shift_q);
      uart_rx_pkg::PAR_FORCE1: par_err_d = ~bit_i;
      default:                 par_err_d = bit_i; // Forced 0
    endcase
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!rxd_sync_i) state_d = ST_START;
      end
      ST_START: begin
        // A high start sample is a glitch
        if (center_i) state_d = bit_i ? ST_IDLE : ST_DATA;
      end
      ST_DATA: begin
        if (center_i && (bit_cnt_q == last_idx)) begin
          state_d = lcr_i.par_en ? ST_PARITY : ST_STOP;
        end
      end
      ST_PARITY: begin
        if (center_i) state_d = ST_STOP;
      end
      ST_STOP: begin
        if (center_i) state_d = bit_i ? ST_IDLE : ST_RESYNC; // Low stop is framing err
      end
      ST_RESYNC: begin
        state_d = rxd_sync_i ? ST_IDLE : ST_START; // Keep bit grid while low
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      push_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      push_q  <= stop_done; // Cycle after stop center
      if (state_q == ST_START) begin
        bit_cnt_q <= '0;
      end else if ((state_q == ST_DATA) && center_i) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Shift register and flags
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == ST_START) begin
      shift_q   <= '0;
      ones_q    <= 1'b0;
      par_err_q <= 1'b0;
    end else if (center_i) begin
      if (state_q == ST_DATA) shift_q[bit_cnt_q] <= bit_i;
      if (state_q == ST_PARITY) par_err_q <= par_err_d;
      if (state_q inside {ST_DATA, ST_PARITY}) ones_q <= ones_q | bit_i;
    end
    if (stop_done) begin
      entry_q.char      <= shift_q;
      entry_q.par_err   <= par_err_q;
      entry_q.frame_err <= ~bit_i;
      entry_q.brk       <= ~(ones_q | bit_i); // Whole frame low
    end
  end

  assign start_seen_o = (state_q == ST_IDLE) & ~rxd_sync_i;
  assign idle_o       = (state_q == ST_IDLE);
  assign push_o       = push_q;
  assign entry_o      = entry_q;

  // Push follows a stop bit that closed a full data word
  a_push_after_stop : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_o |-> (state_q inside {ST_IDLE, ST_RESYNC}) &&
               (bit_cnt_q == 3'(last_idx + 3'd1)))
    else $error("FIFO push without a complete frame");

endmodule

// ==== uart_rx_fifo.sv ====
module uart_rx_fifo #(
  parameter int FIFO_DEPTH = 16 // Power of two
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  uart_rx_pkg::rx_entry_t entry_i,
  input  logic                   pop_i,
  input  logic                   flush_i,
  input  logic [1:0]             trig_level_i,
  input  logic                   ovr_clr_i,
  output uart_rx_pkg::rx_entry_t head_o,
  output logic                   empty_o,
  output logic                   overrun_o,
  output logic                   trigger_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  uart_rx_pkg::rx_entry_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;  // Usage
  logic [CNT_W-1:0]       trig_thr;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;
  logic                   overrun_q;
  logic                   trigger_q;

  assign full    = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full & ~flush_i;  // Dropped when full
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  always_comb begin
    case (trig_level_i)
      2'd0:    trig_thr = CNT_W'(1);
      2'd1:    trig_thr = CNT_W'(4);
      2'd2:    trig_thr = CNT_W'(8);
      default: trig_thr = CNT_W'(14);
    endcase
  end

  // --------------------------------------------------
  // Pointers, count and flags
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_q <= 1'b0;
      trigger_q <= 1'b0;
    end else begin
      if (flush_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
      end
      if (push_i && full) begin
        overrun_q <= 1'b1; // Sticky and a set wins over a clear
      end else if (ovr_clr_i) begin
        overrun_q <= 1'b0;
      end
      trigger_q <= (count_q >= trig_thr);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= entry_i;
  end

  assign head_o    = mem_q[rd_ptr_q];
  assign overrun_o = overrun_q;
  assign trigger_o = trigger_q;

  // Count stays within depth and agrees with the pointer distance
  a_count_bound : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count_q <= CNT_W'(FIFO_DEPTH)) &&
    (PTR_W'(count_q) == PTR_W'(wr_ptr_q - rd_ptr_q)))
    else $error("FIFO count out of step with its pointers");

endmodule

// ==== uart_rx_wb_regs.sv ====
module uart_rx_wb_regs (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  uart_rx_pkg::wb_req_t   wb_i,
  output uart_rx_pkg::wb_rsp_t   wb_o,
  input  uart_rx_pkg::rx_entry_t head_i,
  input  logic                   empty_i,
  input  logic                   overrun_i,
  output uart_rx_pkg::lcr_t      lcr_o,
  output logic [1:0]             trig_level_o,
  output logic                   pop_o,
  output logic                   flush_o,
  output logic                   ovr_clr_o
);

  localparam logic [7:0] LCR_MASK = 8'h3B; // Reserved bits read as zero

  uart_rx_pkg::lcr_t lcr_q;
  uart_rx_pkg::fcr_t fcr_q;
  uart_rx_pkg::fcr_t fcr_wr;
  uart_rx_pkg::lsr_t lsr;
  logic              req;
  logic              ack_q;
  logic              rd_ack;
  logic              wr_ack;
  logic [7:0]        rdat_d;
  logic [7:0]        rdat_q;

  // --------------------------------------------------
  // Bus handshake
  // --------------------------------------------------
  assign req    = wb_i.cyc & wb_i.stb & ~ack_q; // New access
  assign rd_ack = ack_q & ~wb_i.we;             // Master holds adr through ack
  assign wr_ack = ack_q & wb_i.we;
  assign fcr_wr = uart_rx_pkg::fcr_t'(wb_i.dat);

  // Live line status with the errors of the head entry
  always_comb begin
    lsr            = '0;
    lsr.data_ready = ~empty_i;
    lsr.overrun    = overrun_i;
    lsr.par_err    = head_i.par_err & ~empty_i;
    lsr.frame_err  = head_i.frame_err & ~empty_i;
    lsr.brk        = head_i.brk & ~empty_i;
  end

  always_comb begin
    case (wb_i.adr)
      uart_rx_pkg::ADDR_RHR: rdat_d = empty_i ? '0 : head_i.char;
      uart_rx_pkg::ADDR_LCR: rdat_d = lcr_q;
      uart_rx_pkg::ADDR_FCR: rdat_d = fcr_q;
      uart_rx_pkg::ADDR_LSR: rdat_d = lsr;
      default:               rdat_d = '0;
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      lcr_q <= uart_rx_pkg::lcr_t'(8'h03); // 8N1
      fcr_q <= '0;
    end else begin
      ack_q <= req;
      if (wr_ack && (wb_i.adr == uart_rx_pkg::ADDR_LCR)) begin
        lcr_q <= uart_rx_pkg::lcr_t'(wb_i.dat & LCR_MASK);
      end
      if (wr_ack && (wb_i.adr == uart_rx_pkg::ADDR_FCR)) begin
        fcr_q.trig_level <= fcr_wr.trig_level; // Reset bit never stored
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) rdat_q <= rdat_d;
  end

  // Side effects in the ack cycle
  assign pop_o     = rd_ack & (wb_i.adr == uart_rx_pkg::ADDR_RHR);
  assign ovr_clr_o = rd_ack & (wb_i.adr == uart_rx_pkg::ADDR_LSR);
  assign flush_o   = wr_ack & (wb_i.adr == uart_rx_pkg::ADDR_FCR) & fcr_wr.rx_fifo_rst;

  assign lcr_o        = lcr_q;
  assign trig_level_o = fcr_q.trig_level;
  assign wb_o         = '{ack: ack_q, dat: rdat_q};

  // Side effects in the ack cycle rely on the request held until then
  a_ack_held_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_o.ack |-> wb_i.cyc && wb_i.stb && $stable(wb_i.adr) && $stable(wb_i.we) &&
                 (!wb_i.we || $stable(wb_i.dat)))
    else $error("Wishbone request changed before ack");

endmodule

// ==== uart_rx_top.sv ====
module uart_rx_top #(
  parameter int CLKS_PER_TICK = 8,
  parameter int FIFO_DEPTH    = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 rxd_i,     // Serial in
  input  uart_rx_pkg::wb_req_t wb_i,
  output uart_rx_pkg::wb_rsp_t wb_o,
  output logic                 trigger_o  // FIFO level reached
);

  logic                            tick;
  logic [uart_rx_pkg::PHASE_W-1:0] phase;
  logic                            center;
  logic                            start_seen;
  logic                            idle;
  logic                            rxd_sync;
  logic                            rx_bit;
  logic                            push;
  uart_rx_pkg::rx_entry_t          entry;
  uart_rx_pkg::rx_entry_t          head;
  uart_rx_pkg::lcr_t               lcr;
  logic [1:0]                      trig_level;
  logic                            pop;
  logic                            flush;
  logic                            ovr_clr;
  logic                            empty;
  logic                            overrun;

  // --------------------------------------------------
  // Serial front end
  // --------------------------------------------------
  uart_rx_bit_timing #(
    .CLKS_PER_TICK (CLKS_PER_TICK)
  ) u_bit_timing (
    .clk_i, .arst_n_i,
    .start_seen_i (start_seen),
    .idle_i       (idle),
    .tick_o       (tick),
    .phase_o      (phase),
    .center_o     (center)
  );

  uart_rx_line_filter u_line_filter (
    .clk_i, .arst_n_i, .rxd_i,
    .tick_i     (tick),
    .phase_i    (phase),
    .rxd_sync_o (rxd_sync),
    .bit_o      (rx_bit)
  );

  uart_rx_deframer u_deframer (
    .clk_i, .arst_n_i,
    .rxd_sync_i   (rxd_sync),
    .bit_i        (rx_bit),
    .center_i     (center),
    .lcr_i        (lcr),
    .start_seen_o (start_seen),
    .idle_o       (idle),
    .push_o       (push),
    .entry_o      (entry)
  );

  // --------------------------------------------------
  // Storage and host side
  // --------------------------------------------------
  uart_rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i, .arst_n_i, .trigger_o,
    .push_i       (push),
    .entry_i      (entry),
    .pop_i        (pop),
    .flush_i      (flush),
    .trig_level_i (trig_level),
    .ovr_clr_i    (ovr_clr),
    .head_o       (head),
    .empty_o      (empty),
    .overrun_o    (overrun)
  );

  uart_rx_wb_regs u_wb_regs (
    .clk_i, .arst_n_i, .wb_i, .wb_o,
    .head_i       (head),
    .empty_i      (empty),
    .overrun_i    (overrun),
    .lcr_o        (lcr),
    .trig_level_o (trig_level),
    .pop_o        (pop),
    .flush_o      (flush),
    .ovr_clr_o    (ovr_clr)
  );

endmodule

// ==== tb_uart_rx_clk.sv ====
module tb_uart_rx_clk #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o; // 25 MHz
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1; // Release on a clock edge
  end

endmodule

// ==== tb_uart_rx_checker.sv ====
module tb_uart_rx_checker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  uart_rx_pkg::wb_req_t wb_req_i,
  input  uart_rx_pkg::wb_rsp_t wb_rsp_i,
  input  logic                 trigger_i,
  output int                   err_cnt_o,
  output int                   chk_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // One entry per bus read, in issue order
  string      name_q [$];
  logic [7:0] exp_q  [$];
  bit         use_q  [$]; // Clear for polling reads
  int         err_cnt = 0;
  int         chk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  task automatic expect_read(input string name, input logic [7:0] exp, input bit use_it);
    name_q.push_back(name);
    exp_q.push_back(exp);
    use_q.push_back(use_it);
  endtask

  task automatic report_problem(input string msg);
    err_cnt++;
    $display("ERROR: %s", msg);
  endtask

  // Sampled mid cycle, trigger is a registered output
  task automatic check_trigger(input string name, input logic exp);
    @(negedge clk_i);
    chk_cnt++;
    if (trigger_i !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: expected %0b, actual %0b", name, exp, trigger_i);
    end
  endtask

  // --------------------------------------------------
  // Read data monitor
  // --------------------------------------------------
  always @(negedge clk_i) begin : read_monitor
    string      name;
    logic [7:0] exp;
    bit         use_it;
    if (arst_n_i && wb_rsp_i.ack && !wb_req_i.we) begin
      if (name_q.size() == 0) begin
        report_problem("bus read completed with nothing expected");
      end else begin
        name   = name_q.pop_front();
        exp    = exp_q.pop_front();
        use_it = use_q.pop_front();
        if (use_it) begin
          chk_cnt++;
          if (wb_rsp_i.dat !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, wb_rsp_i.dat);
          end
        end
      end
    end
  end

endmodule

// ==== tb_uart_rx.sv ====
module tb_uart_rx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_TICK  = 2;
  localparam int FIFO_DEPTH     = 16;
  localparam int BIT_CLKS       = CLKS_PER_TICK * uart_rx_pkg::OVERSAMPLE; // 32 clocks
  localparam int POLL_LIMIT     = 8;
  localparam int TIMEOUT_CYCLES = 40000; // ~60 frames of 12 bits, plus polling

  logic                   clk;
  logic                   arst_n;
  logic                   rxd;
  uart_rx_pkg::wb_req_t   wb_req;
  uart_rx_pkg::wb_rsp_t   wb_rsp;
  logic                   trigger;
  int                     err_cnt;
  int                     chk_cnt;
  int                     cycles = 0;
  integer                 seed   = 32'h63ce_95f7;
  uart_rx_pkg::lcr_t      cur_lcr;    // Line setup the DUT holds
  uart_rx_pkg::rx_entry_t model_q [$]; // Expected FIFO contents
  bit                     model_ovr;
  logic [7:0]             rd_data;

  tb_uart_rx_clk clk_gen_i (.clk_o(clk), .arst_n_o(arst_n));

  uart_rx_top #(
    .CLKS_PER_TICK (CLKS_PER_TICK),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) dut_i (
    .clk_i (clk), .arst_n_i (arst_n), .rxd_i (rxd),
    .wb_i  (wb_req), .wb_o (wb_rsp), .trigger_o (trigger)
  );

  tb_uart_rx_checker chk_i (
    .clk_i (clk), .arst_n_i (arst_n), .wb_req_i (wb_req), .wb_rsp_i (wb_rsp),
    .trigger_i (trigger), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [7:0] char_mask(input uart_rx_pkg::lcr_t lcr);
    return 8'hFF >> (3 - int'(lcr.word_len)); // 5 to 8 bits
  endfunction

  // Parity bit a correct transmitter sends
  function automatic logic parity_bit(input logic [7:0] data, input uart_rx_pkg::lcr_t lcr);
    logic [7:0] c;
    c = data & char_mask(lcr);
    case (lcr.par_type)
      uart_rx_pkg::PAR_ODD:    return ~^c;
      uart_rx_pkg::PAR_EVEN:   return ^c;
      uart_rx_pkg::PAR_FORCE1: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic uart_rx_pkg::rx_entry_t expected_entry(input logic [7:0] data,
      input uart_rx_pkg::lcr_t lcr, input logic par_bit, input logic stop_bit);
    uart_rx_pkg::rx_entry_t e;
    logic [7:0]             c;
    c      = data & char_mask(lcr);
    e      = '0;
    e.char = c;
    if (lcr.par_en) begin
      case (lcr.par_type)
        uart_rx_pkg::PAR_ODD:    e.par_err = (par_bit == ^c);
        uart_rx_pkg::PAR_EVEN:   e.par_err = (par_bit != ^c);
        uart_rx_pkg::PAR_FORCE1: e.par_err = !par_bit;
        default:                 e.par_err = par_bit;
      endcase
    end
    e.frame_err = !stop_bit;
    e.brk       = (c == 8'h00) && !stop_bit && !(lcr.par_en && par_bit); // Whole frame low
    return e;
  endfunction

  function automatic logic [7:0] model_lsr();
    uart_rx_pkg::lsr_t l;
    l         = '0;
    l.overrun = model_ovr;
    if (model_q.size() != 0) begin
      l.data_ready = 1'b1;
      l.par_err    = model_q[0].par_err;
      l.frame_err  = model_q[0].frame_err;
      l.brk        = model_q[0].brk;
    end
    return l;
  endfunction

  // --------------------------------------------------
  // Serial and bus drivers
  // --------------------------------------------------
  task automatic drive_bit(input logic b);
    @(posedge clk);
    rxd <= b;
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_char(input logic [7:0] data, input logic par_bit, input logic stop_bit);
    int i;
    drive_bit(1'b0); // Start
    for (i = 0; i < 5 + int'(cur_lcr.word_len); i++) drive_bit(data[i]);
    if (cur_lcr.par_en) drive_bit(par_bit);
    drive_bit(stop_bit);
    drive_bit(1'b1); // Idle bit, resync sees a high line
    if (model_q.size() < FIFO_DEPTH) begin
      model_q.push_back(expected_entry(data, cur_lcr, par_bit, stop_bit));
    end else begin
      model_ovr = 1'b1; // Dropped by a full FIFO
    end
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] data);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: data};
    do @(negedge clk); while (!wb_rsp.ack);
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic bus_read(input string name, input logic [1:0] adr, input logic [7:0] exp,
      input bit use_it, output logic [7:0] data);
    chk_i.expect_read(name, exp, use_it);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
    do @(negedge clk); while (!wb_rsp.ack);
    data = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;
    if (adr == uart_rx_pkg::ADDR_LSR) model_ovr = 1'b0; // Read clears overrun
  endtask

  task automatic set_lcr(input uart_rx_pkg::lcr_t l);
    bus_write(uart_rx_pkg::ADDR_LCR, l);
    cur_lcr = l;
  endtask

  // Poll data_ready, then check LSR and RHR against the model head
  task automatic read_entry(input string name);
    logic [7:0] d;
    int         n;
    n = 0;
    d = 8'h00;
    while (!d[0] && n < POLL_LIMIT) begin
      bus_read({name, " poll"}, uart_rx_pkg::ADDR_LSR, 8'h00, 1'b0, d);
      n++;
    end
    if (!d[0]) chk_i.report_problem({name, ": data_ready never came up"});
    bus_read({name, " lsr"}, uart_rx_pkg::ADDR_LSR, model_lsr(), 1'b1, d);
    bus_read({name, " rhr"}, uart_rx_pkg::ADDR_RHR,
             (model_q.size() != 0) ? model_q[0].char : 8'h00, 1'b1, d);
    if (model_q.size() != 0) void'(model_q.pop_front());
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    uart_rx_pkg::lcr_t l;
    logic [7:0]        data;
    int                i;
    int                wl;
    int                pt;
    rxd       = 1'b1;
    wb_req    = '0;
    cur_lcr   = uart_rx_pkg::lcr_t'(8'h03);
    model_ovr = 1'b0;
    wait (arst_n === 1'b1);
    @(posedge clk);
    bus_read("reset lcr", uart_rx_pkg::ADDR_LCR, 8'h03, 1'b1, rd_data);

    for (i = 0; i < 20; i++) begin // 8N1 stream
      data = 8'($random(seed));
      send_char(data, 1'b0, 1'b1);
      read_entry($sformatf("8n1[%0d]", i));
    end

    for (wl = 0; wl < 3; wl++) begin // Short words, every parity type
      for (pt = 0; pt < 4; pt++) begin
        l          = '0;
        l.word_len = uart_rx_pkg::word_len_e'(wl);
        l.par_en   = 1'b1;
        l.par_type = uart_rx_pkg::parity_e'(pt);
        set_lcr(l);
        data = 8'($random(seed));
        send_char(data, parity_bit(data, l), 1'b1);
        read_entry($sformatf("len%0d par%0d good", 5 + wl, pt));
        data = 8'($random(seed));
        send_char(data, ~parity_bit(data, l), 1'b1); // Wrong parity bit
        read_entry($sformatf("len%0d par%0d bad", 5 + wl, pt));
      end
    end
    set_lcr(uart_rx_pkg::lcr_t'(8'h03));

    data = 8'($random(seed)); // Framing error, break, recovery
    send_char(data, 1'b0, 1'b0);
    read_entry("frame err");
    send_char(8'h00, 1'b0, 1'b0);
    read_entry("break");
    data = 8'($random(seed));
    send_char(data, 1'b0, 1'b1);
    read_entry("after resync");

    for (i = 0; i < FIFO_DEPTH + 1; i++) begin // One more than the FIFO holds
      data = 8'($random(seed));
      send_char(data, 1'b0, 1'b1);
    end
    bus_read("overrun lsr", uart_rx_pkg::ADDR_LSR, model_lsr(), 1'b1, rd_data);
    for (i = 0; i < FIFO_DEPTH; i++) read_entry($sformatf("drain[%0d]", i));
    bus_read("overrun cleared lsr", uart_rx_pkg::ADDR_LSR, model_lsr(), 1'b1, rd_data);

    bus_write(uart_rx_pkg::ADDR_FCR, 8'h40); // Trigger level 4
    for (i = 0; i < 3; i++) send_char(8'($random(seed)), 1'b0, 1'b1);
    chk_i.check_trigger("trigger at 3", 1'b0);
    send_char(8'($random(seed)), 1'b0, 1'b1);
    chk_i.check_trigger("trigger at 4", 1'b1);
    bus_write(uart_rx_pkg::ADDR_FCR, 8'h42); // Level 4 plus FIFO reset
    model_q.delete();
    bus_read("flush lsr", uart_rx_pkg::ADDR_LSR, model_lsr(), 1'b1, rd_data);
    chk_i.check_trigger("trigger after flush", 1'b0);
    bus_read("fcr readback", uart_rx_pkg::ADDR_FCR, 8'h40, 1'b1, rd_data);

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, checks: %0d, errors: %0d", cycles, chk_cnt, err_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
uart_rx_pkg.sv
uart_rx_bit_timing.sv
uart_rx_line_filter.sv
uart_rx_deframer.sv
uart_rx_fifo.sv
uart_rx_wb_regs.sv
uart_rx_top.sv
tb_uart_rx_clk.sv
tb_uart_rx_checker.sv
tb_uart_rx.sv
